/* src.f */
+incdir+source
source/duck_hunt_pkg.sv
source/vga_timing.sv
source/sprite_rom.sv
source/shot_tracker.sv
source/color_mapper.sv
source/duck_hunt_video.sv
dv/duck_hunt_asserts.sv
dv/duck_hunt_tb.sv

/* Bender.yml */
package:
  name: duck_hunt_video

sources:
  - include_dirs:
      - source
    files:
      - source/duck_hunt_pkg.sv
      - source/vga_timing.sv
      - source/sprite_rom.sv
      - source/shot_tracker.sv
      - source/color_mapper.sv
      - source/duck_hunt_video.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/duck_hunt_asserts.sv
      - dv/duck_hunt_tb.sv

/* dv/duck_hunt_tb.sv */
//--------------------------------------------------------------------------
// duck hunt video testbench
// seeded random scenes and mouse presses, a cycle model of the raster,
// the sprite layers and the shot tracker, with per-cycle output checks
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module duck_hunt_tb;
	import duck_hunt_pkg::*;

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
	localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;
	// three full frames
	localparam int RUN_CYCLES = 3 * H_TOTAL * V_TOTAL + 8;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + 40000;

	logic        vga_clk;
	logic        Reset;
	coord_t      cursor_x;
	coord_t      cursor_y;
	coord_t      dog_x;
	coord_t      dog_y;
	frame_t      dog_frame;
	logic        dog_hidden;
	coord_t      duck_x;
	coord_t      duck_y;
	frame_t      duck_frame;
	duck_color_t duck_color;
	logic        duck_hidden;
	logic        mouse_left;
	logic        reload;
	logic        hs;
	logic        vs;
	rgb4_t       red;
	rgb4_t       green;
	rgb4_t       blue;
	logic        duck_hit;

	// ----------------------------------------------------------------------
	// model state
	// ----------------------------------------------------------------------
	int          mx;
	int          my;
	int          s1_x;
	int          s1_y;
	bit          s1_vis;
	bit          hs_pipe;
	bit          vs_pipe;
	bit          m_meta;
	bit          m_sync;
	bit          m_prev;
	bit          m_accept;
	int          m_flash_left;
	int          m_ammo;
	logic [11:0] exp_rgb = 12'h000;
	logic        exp_hs = 1'b1;
	logic        exp_vs = 1'b1;
	logic        exp_hit = 1'b0;

	int          color_errors = 0;
	int          sync_errors = 0;
	int          hit_errors = 0;
	int          assert_errors;
	int          presses = 0;
	int          hits_seen = 0;
	int          cycle_count = 0;
	int          hold_left = 0;
	int          wait_left = 3000;
	int          scenes = 0;
	logic        vs_prev;

	duck_hunt_video u_duck_hunt_video (
		.vga_clk     (vga_clk),
		.Reset       (Reset),
		.cursor_x    (cursor_x),
		.cursor_y    (cursor_y),
		.dog_x       (dog_x),
		.dog_y       (dog_y),
		.dog_frame   (dog_frame),
		.dog_hidden  (dog_hidden),
		.duck_x      (duck_x),
		.duck_y      (duck_y),
		.duck_frame  (duck_frame),
		.duck_color  (duck_color),
		.duck_hidden (duck_hidden),
		.mouse_left  (mouse_left),
		.reload      (reload),
		.hs          (hs),
		.vs          (vs),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.duck_hit    (duck_hit)
	);

	initial
	begin
		vga_clk = 1'b0;
		forever #5 vga_clk = ~vga_clk;
	end

	// art rule, transparent border ring
	function automatic int art_index(input int frame, input int col, input int row,
		input int w, input int h, input int bits);
		if (col == 0 || row == 0 || col == w - 1 || row == h - 1)
			return 0;
		return (col + 2 * row + frame) % (1 << bits);
	endfunction

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic logic [11:0] expected_rgb(input int x, input int y, input bit vis,
		input bit flash, input int ammo);
		int dx;
		int dy;
		int col;
		int row;
		int idx;
		int k;
		logic [3:0] base;
		if (!vis)
			return 12'h000;
		dx = abs_int(x - int'(cursor_x));
		dy = abs_int(y - int'(cursor_y));
		if (flash)
			return (dx <= `FLASH_HALF && dy <= `FLASH_HALF) ? 12'hFFF : 12'h000;
		if (dx + dy <= `CURSOR_SIZE)
			return 12'hFFF;
		col = x - int'(dog_x);
		row = y - int'(dog_y);
		if (!dog_hidden && col >= 0 && col < `DOG_W && row >= 0 && row < `DOG_H)
		begin
			idx = art_index(int'(dog_frame), col, row, `DOG_W, `DOG_H, 4);
			if (idx != 0)
				return {4'(idx), 4'(15 - idx), 4'd8};
		end
		col = x - int'(duck_x);
		row = y - int'(duck_y);
		if (!duck_hidden && col >= 0 && col < `DUCK_W && row >= 0 && row < `DUCK_H)
		begin
			idx = art_index(int'(duck_frame), col, row, `DUCK_W, `DUCK_H, 3);
			base = 4'(2 * idx);
			if (idx != 0)
			begin
				if (duck_color == DUCK_RED)
					return {4'd15, base, base};
				else if (duck_color == DUCK_PINK)
					return {4'd15, base, 4'd12};
				else
					return {base, base, base};
			end
		end
		// squares still loaded, left to right
		for (k = 0; k < `AMMO_MAX; k++)
		begin
			if (k < `AMMO_MAX - ammo &&
				x >= `AMMO_X0 + k * `AMMO_PITCH && x < `AMMO_X0 + k * `AMMO_PITCH + `AMMO_W &&
				y >= `AMMO_Y && y < `AMMO_Y + `AMMO_H)
				return {3{`AMMO_GREY}};
		end
		return {3{`BG_LEVEL}};
	endfunction

	// strictly inside the duck box shrunk by the margin
	function automatic bit cursor_on_duck();
		int cx;
		int cy;
		int bx;
		int by;
		cx = int'(cursor_x);
		cy = int'(cursor_y);
		bx = int'(duck_x);
		by = int'(duck_y);
		return !duck_hidden &&
			cx > bx + `HIT_MARGIN && cx < bx + `DUCK_W - `HIT_MARGIN &&
			cy > by + `HIT_MARGIN && cy < by + `DUCK_H - `HIT_MARGIN;
	endfunction

	// ----------------------------------------------------------------------
	// cycle model, state after each rising edge
	// ----------------------------------------------------------------------
	always @(posedge vga_clk)
	begin
		if (Reset)
		begin
			mx = 0;
			my = 0;
			s1_x = 0;
			s1_y = 0;
			s1_vis = 1'b0;
			hs_pipe = 1'b1;
			vs_pipe = 1'b1;
			exp_rgb = 12'h000;
			exp_hs = 1'b1;
			exp_vs = 1'b1;
			exp_hit = 1'b0;
			m_meta = 1'b0;
			m_sync = 1'b0;
			m_prev = 1'b0;
			m_flash_left = 0;
			m_ammo = 0;
		end
		else
		begin
			exp_rgb = expected_rgb(s1_x, s1_y, s1_vis, m_flash_left != 0, m_ammo);
			s1_x = mx;
			s1_y = my;
			s1_vis = (mx < `H_VISIBLE) && (my < `V_VISIBLE);
			exp_hs = hs_pipe;
			exp_vs = vs_pipe;
			hs_pipe = !(mx >= H_SYNC_START && mx < H_SYNC_START + `H_SYNC);
			vs_pipe = !(my >= V_SYNC_START && my < V_SYNC_START + `V_SYNC);
			mx = mx + 1;
			if (mx == H_TOTAL)
			begin
				mx = 0;
				my = (my == V_TOTAL - 1) ? 0 : my + 1;
			end
			// shot tracker, two-flop sync then rising edge
			m_accept = m_sync && !m_prev && (m_ammo < `AMMO_MAX);
			exp_hit = m_accept && cursor_on_duck();
			if (m_accept)
			begin
				m_flash_left = `FLASH_CYCLES;
				presses++;
			end
			else if (m_flash_left > 0)
				m_flash_left = m_flash_left - 1;
			if (reload)
				m_ammo = 0;
			else if (m_accept)
				m_ammo = m_ammo + 1;
			m_prev = m_sync;
			m_sync = m_meta;
			m_meta = mouse_left;
		end
	end

	task automatic report_value(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		$display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
	endtask

	// outputs are settled by the falling edge
	always @(negedge vga_clk)
	begin
		if ({red, green, blue} !== exp_rgb)
		begin
			color_errors++;
			report_value("rgb", exp_rgb, {red, green, blue});
		end
		if (hs !== exp_hs)
		begin
			sync_errors++;
			report_value("hs", exp_hs, hs);
		end
		if (vs !== exp_vs)
		begin
			sync_errors++;
			report_value("vs", exp_vs, vs);
		end
		if (duck_hit !== exp_hit)
		begin
			hit_errors++;
			report_value("duck_hit", exp_hit, duck_hit);
		end
		if (duck_hit === 1'b1)
			hits_seen++;
	end

	always @(posedge vga_clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic randomize_scene();
		int ux;
		int uy;
		int nx;
		int ny;
		ux = int'($urandom % `H_VISIBLE);
		uy = int'($urandom % `V_VISIBLE);
		// half the scenes put the dog over the duck
		if ($urandom % 2 == 0)
		begin
			nx = ux + int'($urandom % 16) - 8;
			ny = uy + int'($urandom % 12) - 6;
		end
		else
		begin
			nx = int'($urandom % `H_VISIBLE);
			ny = int'($urandom % `V_VISIBLE);
		end
		if (nx < 0)
			nx = 0;
		if (ny < 0)
			ny = 0;
		duck_x <= coord_t'(ux);
		duck_y <= coord_t'(uy);
		duck_frame <= frame_t'($urandom);
		// each scene takes the next duck variant
		duck_color <= duck_color_t'(scenes % 3);
		scenes++;
		duck_hidden <= ($urandom % 4 == 0);
		dog_x <= coord_t'(nx);
		dog_y <= coord_t'(ny);
		dog_frame <= frame_t'($urandom);
		dog_hidden <= ($urandom % 4 == 0);
		reload <= ($urandom % 2 == 0);
	endtask

	// pos is the raster step the flash will be drawing shortly
	task automatic aim_cursor(input int pos);
		int pick;
		pick = int'($urandom % 3);
		if (pick == 0)
		begin
			cursor_x <= coord_t'(int'(duck_x) + int'($urandom % 13));
			cursor_y <= coord_t'(int'(duck_y) + int'($urandom % 13));
		end
		else if (pick == 1)
		begin
			cursor_x <= coord_t'(pos % H_TOTAL);
			cursor_y <= coord_t'((pos / H_TOTAL) % V_TOTAL);
		end
		else
		begin
			cursor_x <= coord_t'($urandom % `H_VISIBLE);
			cursor_y <= coord_t'($urandom % `V_VISIBLE);
		end
	endtask

	task automatic drive_mouse(input int step);
		if (hold_left > 0)
		begin
			hold_left--;
			if (hold_left == 0)
				mouse_left <= 1'b0;
		end
		else if (wait_left > 0)
			wait_left--;
		else
		begin
			aim_cursor(step + 20);
			mouse_left <= 1'b1;
			// some presses come right after a fresh magazine
			reload <= ($urandom % 3 == 0);
			hold_left = 2 + int'($urandom % 6);
			wait_left = 4000 + int'($urandom % 40000);
		end
	endtask

	initial
	begin
		void'($urandom(92890));
		Reset = 1'b1;
		mouse_left = 1'b0;
		reload = 1'b0;
		cursor_x = '0;
		cursor_y = '0;
		dog_x = '0;
		dog_y = '0;
		dog_frame = '0;
		dog_hidden = 1'b0;
		duck_x = '0;
		duck_y = '0;
		duck_frame = '0;
		duck_color = DUCK_BLACK;
		duck_hidden = 1'b0;
		randomize_scene();
		repeat (2) @(posedge vga_clk);
		Reset <= 1'b0;
		vs_prev = 1'b1;
		for (int n = 0; n < RUN_CYCLES; n++)
		begin
			@(posedge vga_clk);
			reload <= 1'b0;
			// hide flags anywhere in the frame
			if ($urandom % 1000 == 0)
			begin
				dog_hidden <= ($urandom % 4 == 0);
				duck_hidden <= ($urandom % 4 == 0);
			end
			// new scene while vsync hides the change
			if (vs_prev && !vs)
				randomize_scene();
			vs_prev = vs;
			drive_mouse(n);
		end
		repeat (2) @(posedge vga_clk);
		assert_errors = u_duck_hunt_video.u_shot_tracker.u_tracker_asserts.fail_count +
			u_duck_hunt_video.u_vga_timing.u_timing_asserts.fail_count;
		$display("cycles %0d, presses %0d, hits %0d, errors rgb %0d sync %0d hit %0d assert %0d",
			cycle_count, presses, hits_seen, color_errors, sync_errors, hit_errors,
			assert_errors);
		if (color_errors + sync_errors + hit_errors + assert_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* dv/duck_hunt_asserts.sv */
//--------------------------------------------------------------------------
// duck hunt assertions
// one-cycle hit pulse, ammo saturation and sync inside blanking, bound
// into the shot tracker and the timing generator
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module duck_hunt_asserts (
	input logic       vga_clk,
	input logic       Reset,
	input logic       duck_hit,
	input logic [1:0] ammo_used,
	input logic       reload,
	input logic       hs,
	input logic       vs,
	input logic       blank
);
	int fail_count = 0;

	hit_one_cycle: assert property (@(posedge vga_clk) disable iff (Reset)
		duck_hit |=> !duck_hit)
	else
	begin
		$error("duck_hit held for more than one cycle");
		fail_count++;
	end

	// an empty gun stays empty until reload, it never wraps past the max
	ammo_saturates: assert property (@(posedge vga_clk) disable iff (Reset)
		(ammo_used == 2'(`AMMO_MAX)) && !reload |=> (ammo_used == 2'(`AMMO_MAX)))
	else
	begin
		$error("ammo_used went past the magazine size");
		fail_count++;
	end

	// sync pulses only inside the blanking interval
	sync_blanked: assert property (@(posedge vga_clk) disable iff (Reset)
		(!hs || !vs) |-> !blank)
	else
	begin
		$error("sync active inside the visible area");
		fail_count++;
	end

endmodule

bind shot_tracker duck_hunt_asserts u_tracker_asserts (
	.vga_clk   (vga_clk),
	.Reset     (Reset),
	.duck_hit  (duck_hit),
	.ammo_used (ammo_used),
	.reload    (reload),
	.hs        (1'b1),
	.vs        (1'b1),
	.blank     (1'b0)
);

bind vga_timing duck_hunt_asserts u_timing_asserts (
	.vga_clk   (vga_clk),
	.Reset     (Reset),
	.duck_hit  (1'b0),
	.ammo_used (2'd0),
	.reload    (1'b0),
	.hs        (hs),
	.vs        (vs),
	.blank     (blank)
);

/* source/duck_hunt_video.sv */
//--------------------------------------------------------------------------
// duck hunt video top
// raster timing, dog and duck sprite roms, shot tracking and the color
// mapper, giving registered rgb two cycles behind the counters
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module duck_hunt_video (
	input  logic                       vga_clk,
	input  logic                       Reset,
	input  duck_hunt_pkg::coord_t      cursor_x,
	input  duck_hunt_pkg::coord_t      cursor_y,
	input  duck_hunt_pkg::coord_t      dog_x,
	input  duck_hunt_pkg::coord_t      dog_y,
	input  duck_hunt_pkg::frame_t      dog_frame,
	input  logic                       dog_hidden,
	input  duck_hunt_pkg::coord_t      duck_x,
	input  duck_hunt_pkg::coord_t      duck_y,
	input  duck_hunt_pkg::frame_t      duck_frame,
	input  duck_hunt_pkg::duck_color_t duck_color,
	input  logic                       duck_hidden,
	input  logic                       mouse_left,
	input  logic                       reload,
	output logic                       hs,
	output logic                       vs,
	output duck_hunt_pkg::rgb4_t       red,
	output duck_hunt_pkg::rgb4_t       green,
	output duck_hunt_pkg::rgb4_t       blue,
	output logic                       duck_hit
);
	import duck_hunt_pkg::*;

	coord_t     draw_x;
	coord_t     draw_y;
	logic       blank;
	dog_pix_t   dog_pix;
	duck_pix_t  duck_pix;
	logic       shot_flash;
	logic [1:0] ammo_used;

	vga_timing u_vga_timing (
		.vga_clk (vga_clk),
		.Reset   (Reset),
		.draw_x  (draw_x),
		.draw_y  (draw_y),
		.hs      (hs),
		.vs      (vs),
		.blank   (blank)
	);

	// sprite-relative address, out-of-box offsets read back as 0
	sprite_rom #(
		.pix_t  (dog_pix_t),
		.WIDTH  (`DOG_W),
		.HEIGHT (`DOG_H)
	) u_dog_rom (
		.vga_clk (vga_clk),
		.frame   (dog_frame),
		.col     (draw_x - dog_x),
		.row     (draw_y - dog_y),
		.pix     (dog_pix)
	);

	sprite_rom #(
		.pix_t  (duck_pix_t),
		.WIDTH  (`DUCK_W),
		.HEIGHT (`DUCK_H)
	) u_duck_rom (
		.vga_clk (vga_clk),
		.frame   (duck_frame),
		.col     (draw_x - duck_x),
		.row     (draw_y - duck_y),
		.pix     (duck_pix)
	);

	shot_tracker u_shot_tracker (
		.vga_clk     (vga_clk),
		.Reset       (Reset),
		.mouse_left  (mouse_left),
		.reload      (reload),
		.cursor_x    (cursor_x),
		.cursor_y    (cursor_y),
		.duck_x      (duck_x),
		.duck_y      (duck_y),
		.duck_hidden (duck_hidden),
		.shot_flash  (shot_flash),
		.ammo_used   (ammo_used),
		.duck_hit    (duck_hit)
	);

	color_mapper u_color_mapper (
		.vga_clk     (vga_clk),
		.Reset       (Reset),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.blank       (blank),
		.cursor_x    (cursor_x),
		.cursor_y    (cursor_y),
		.dog_x       (dog_x),
		.dog_y       (dog_y),
		.dog_hidden  (dog_hidden),
		.dog_pix     (dog_pix),
		.duck_x      (duck_x),
		.duck_y      (duck_y),
		.duck_hidden (duck_hidden),
		.duck_color  (duck_color),
		.duck_pix    (duck_pix),
		.shot_flash  (shot_flash),
		.ammo_used   (ammo_used),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

endmodule

/* source/color_mapper.sv */
//--------------------------------------------------------------------------
// color mapper
// stacks flash, cursor, dog, duck, ammo squares and background by fixed
// priority and registers the 4-bit red, green and blue outputs
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module color_mapper (
	input  logic                       vga_clk,
	input  logic                       Reset,
	input  duck_hunt_pkg::coord_t      draw_x,
	input  duck_hunt_pkg::coord_t      draw_y,
	input  logic                       blank,
	input  duck_hunt_pkg::coord_t      cursor_x,
	input  duck_hunt_pkg::coord_t      cursor_y,
	input  duck_hunt_pkg::coord_t      dog_x,
	input  duck_hunt_pkg::coord_t      dog_y,
	input  logic                       dog_hidden,
	input  duck_hunt_pkg::dog_pix_t    dog_pix,
	input  duck_hunt_pkg::coord_t      duck_x,
	input  duck_hunt_pkg::coord_t      duck_y,
	input  logic                       duck_hidden,
	input  duck_hunt_pkg::duck_color_t duck_color,
	input  duck_hunt_pkg::duck_pix_t   duck_pix,
	input  logic                       shot_flash,
	input  logic [1:0]                 ammo_used,
	output duck_hunt_pkg::rgb4_t       red,
	output duck_hunt_pkg::rgb4_t       green,
	output duck_hunt_pkg::rgb4_t       blue
);
	import duck_hunt_pkg::*;

	localparam logic [11:0] WHITE = 12'hFFF;

	// position of the pixel whose rom data is arriving now
	coord_t x_q;
	coord_t y_q;
	logic   blank_q;

	coord_t cur_dx;
	coord_t cur_dy;
	coord_t dog_col;
	coord_t dog_row;
	coord_t duck_col;
	coord_t duck_row;
	logic   flash_on;
	logic   cursor_on;
	logic   dog_on;
	logic   duck_on;
	logic   ammo_on;
	logic [11:0] rgb_next;

	function automatic coord_t abs_diff(input coord_t a, input coord_t b);
		return (a >= b) ? a - b : b - a;
	endfunction

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			x_q     <= '0;
			y_q     <= '0;
			blank_q <= 1'b0;
		end
		else
		begin
			x_q     <= draw_x;
			y_q     <= draw_y;
			blank_q <= blank;
		end
	end

	// ----------------------------------------------------------------------
	// layer hits
	// ----------------------------------------------------------------------
	assign cur_dx = abs_diff(x_q, cursor_x);
	assign cur_dy = abs_diff(y_q, cursor_y);

	assign flash_on = (cur_dx <= coord_t'(`FLASH_HALF)) && (cur_dy <= coord_t'(`FLASH_HALF));
	// diamond, |dx| + |dy| within size
	assign cursor_on = ({1'b0, cur_dx} + {1'b0, cur_dy}) <= 11'(`CURSOR_SIZE);

	assign dog_col  = x_q - dog_x;
	assign dog_row  = y_q - dog_y;
	assign duck_col = x_q - duck_x;
	assign duck_row = y_q - duck_y;

	// index 0 is see-through
	assign dog_on = (dog_pix != '0) && !dog_hidden &&
		(dog_col < coord_t'(`DOG_W)) && (dog_row < coord_t'(`DOG_H));
	assign duck_on = (duck_pix != '0) && !duck_hidden &&
		(duck_col < coord_t'(`DUCK_W)) && (duck_row < coord_t'(`DUCK_H));

	// square k stays drawn while still loaded
	always_comb
	begin
		ammo_on = 1'b0;
		for (int k = 0; k < `AMMO_MAX; k++)
		begin
			if ((k < `AMMO_MAX - int'(ammo_used)) &&
				(x_q >= coord_t'(`AMMO_X0 + k * `AMMO_PITCH)) &&
				(x_q < coord_t'(`AMMO_X0 + k * `AMMO_PITCH + `AMMO_W)) &&
				(y_q >= coord_t'(`AMMO_Y)) &&
				(y_q < coord_t'(`AMMO_Y + `AMMO_H)))
				ammo_on = 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// priority select
	// ----------------------------------------------------------------------
	always_comb
	begin
		if (!blank_q)
			rgb_next = '0;
		else if (shot_flash)
			rgb_next = flash_on ? WHITE : 12'h000;
		else if (cursor_on)
			rgb_next = WHITE;
		else if (dog_on)
			rgb_next = dog_palette(dog_pix);
		else if (duck_on)
			rgb_next = duck_palette(duck_pix, duck_color);
		else if (ammo_on)
			rgb_next = {3{`AMMO_GREY}};
		else
			rgb_next = {3{`BG_LEVEL}};
	end

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
			{red, green, blue} <= '0;
		else
			{red, green, blue} <= rgb_next;
	end

endmodule

/* source/shot_tracker.sv */
//--------------------------------------------------------------------------
// shot tracker
// turns left-button presses into a screen flash, a saturating ammo
// count and a one-cycle duck hit pulse
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module shot_tracker (
	input  logic                  vga_clk,
	input  logic                  Reset,
	input  logic                  mouse_left,
	input  logic                  reload,
	input  duck_hunt_pkg::coord_t cursor_x,
	input  duck_hunt_pkg::coord_t cursor_y,
	input  duck_hunt_pkg::coord_t duck_x,
	input  duck_hunt_pkg::coord_t duck_y,
	input  logic                  duck_hidden,
	output logic                  shot_flash,
	output logic [1:0]            ammo_used,
	output logic                  duck_hit
);
	localparam int FLASH_BITS = $clog2(`FLASH_CYCLES + 1);

	logic btn_meta;
	logic btn_sync;
	logic btn_prev;
	logic press;
	logic accept;
	logic in_box;
	logic [FLASH_BITS-1:0] flash_cnt;
	// shrunk hit box, one bit wider so it cannot wrap
	logic [10:0] box_x0;
	logic [10:0] box_x1;
	logic [10:0] box_y0;
	logic [10:0] box_y1;

	// ----------------------------------------------------------------------
	// button sync and rising edge
	// ----------------------------------------------------------------------
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			btn_meta <= 1'b0;
			btn_sync <= 1'b0;
			btn_prev <= 1'b0;
		end
		else
		begin
			btn_meta <= mouse_left;
			btn_sync <= btn_meta;
			btn_prev <= btn_sync;
		end
	end

	assign press = btn_sync & ~btn_prev;
	// an empty gun ignores the trigger
	assign accept = press && (ammo_used < 2'(`AMMO_MAX));

	assign box_x0 = duck_x + 11'(`HIT_MARGIN);
	assign box_x1 = duck_x + 11'(`DUCK_W - `HIT_MARGIN);
	assign box_y0 = duck_y + 11'(`HIT_MARGIN);
	assign box_y1 = duck_y + 11'(`DUCK_H - `HIT_MARGIN);

	assign in_box = ({1'b0, cursor_x} > box_x0) && ({1'b0, cursor_x} < box_x1) &&
		({1'b0, cursor_y} > box_y0) && ({1'b0, cursor_y} < box_y1) && !duck_hidden;

	// ----------------------------------------------------------------------
	// flash, ammo and hit
	// ----------------------------------------------------------------------
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			flash_cnt <= '0;
			ammo_used <= '0;
			duck_hit  <= 1'b0;
		end
		else
		begin
			if (accept)
				flash_cnt <= FLASH_BITS'(`FLASH_CYCLES);
			else if (flash_cnt != '0)
				flash_cnt <= flash_cnt - 1'b1;

			// reload wins over a shot in the same cycle
			if (reload)
				ammo_used <= '0;
			else if (accept)
				ammo_used <= ammo_used + 2'd1;

			duck_hit <= accept && in_box;
		end
	end

	assign shot_flash = (flash_cnt != '0);

endmodule

/* source/sprite_rom.sv */
//--------------------------------------------------------------------------
// sprite rom
// four animation frames of WIDTH x HEIGHT pixel indices, built from the
// procedural sprite art, with a registered read one cycle deep
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module sprite_rom #(
	parameter type pix_t  = duck_hunt_pkg::dog_pix_t,
	parameter int  WIDTH  = `DOG_W,
	parameter int  HEIGHT = `DOG_H
) (
	input  logic                  vga_clk,
	input  duck_hunt_pkg::frame_t frame,
	input  duck_hunt_pkg::coord_t col,
	input  duck_hunt_pkg::coord_t row,
	output pix_t                  pix
);
	import duck_hunt_pkg::*;

	localparam int COL_BITS = $clog2(WIDTH);
	localparam int ROW_BITS = $clog2(HEIGHT);

	pix_t mem [4][HEIGHT][WIDTH];
	logic in_range;

	// contents fixed at elaboration
	initial
	begin
		for (int f = 0; f < 4; f++)
			for (int r = 0; r < HEIGHT; r++)
				for (int c = 0; c < WIDTH; c++)
					mem[f][r][c] = pix_t'(sprite_art(frame_t'(f), c, r, WIDTH, HEIGHT));
	end

	// negative offsets wrap to large values and land here too
	assign in_range = (col < coord_t'(WIDTH)) && (row < coord_t'(HEIGHT));

	always_ff @(posedge vga_clk)
	begin
		if (in_range)
			pix <= mem[frame][row[ROW_BITS-1:0]][col[COL_BITS-1:0]];
		else
			pix <= '0;
	end

endmodule

/* source/vga_timing.sv */
//--------------------------------------------------------------------------
// vga timing generator
// free-running pixel and line counters for an 800x525 raster, sync
// pulses delayed two cycles to line up with the color pipeline, and
// the visible-area flag
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "duck_hunt_config.svh"

module vga_timing (
	input  logic                  vga_clk,
	input  logic                  Reset,
	output duck_hunt_pkg::coord_t draw_x,
	output duck_hunt_pkg::coord_t draw_y,
	output logic                  hs,
	output logic                  vs,
	output logic                  blank
);
	import duck_hunt_pkg::*;

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
	localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;

	logic hs_on;
	logic vs_on;
	// first sync stage, matches the rom read
	logic hs_q;
	logic vs_q;

	// ----------------------------------------------------------------------
	// raster counters
	// ----------------------------------------------------------------------
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			draw_x <= '0;
			draw_y <= '0;
		end
		else if (draw_x == coord_t'(H_TOTAL - 1))
		begin
			draw_x <= '0;
			if (draw_y == coord_t'(V_TOTAL - 1))
				draw_y <= '0;
			else
				draw_y <= draw_y + 10'd1;
		end
		else
		begin
			draw_x <= draw_x + 10'd1;
		end
	end

	// ----------------------------------------------------------------------
	// sync decode, active low at the output
	// ----------------------------------------------------------------------
	assign hs_on = (draw_x >= coord_t'(H_SYNC_START)) && (draw_x < coord_t'(H_SYNC_END));
	assign vs_on = (draw_y >= coord_t'(V_SYNC_START)) && (draw_y < coord_t'(V_SYNC_END));

	// two stages so sync leaves with the pixel it belongs to
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			hs   <= 1'b1;
			vs   <= 1'b1;
		end
		else
		begin
			hs_q <= ~hs_on;
			vs_q <= ~vs_on;
			hs   <= hs_q;
			vs   <= vs_q;
		end
	end

	// high inside the visible window
	assign blank = (draw_x < coord_t'(`H_VISIBLE)) && (draw_y < coord_t'(`V_VISIBLE));

endmodule

/* source/duck_hunt_pkg.sv */
//--------------------------------------------------------------------------
// duck hunt video types
// coordinate, color and sprite index types, plus the procedural sprite
// art and the dog and duck palettes
//--------------------------------------------------------------------------
package duck_hunt_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [3:0] rgb4_t;
	// index 0 is transparent in both sprite formats
	typedef logic [3:0] dog_pix_t;
	typedef logic [2:0] duck_pix_t;
	typedef logic [1:0] frame_t;

	typedef enum logic [1:0] {
		DUCK_BLACK = 2'd0,
		DUCK_RED   = 2'd1,
		DUCK_PINK  = 2'd2
	} duck_color_t;

	// outer ring is always transparent, the caller truncates to pixel width
	function automatic int sprite_art(input frame_t frame, input int col, input int row,
		input int width, input int height);
		if (col == 0 || row == 0 || col == width - 1 || row == height - 1)
			return 0;
		return col + 2 * row + int'(frame);
	endfunction

	// packed as red, green, blue
	function automatic logic [11:0] dog_palette(input dog_pix_t idx);
		rgb4_t r;
		rgb4_t g;
		r = rgb4_t'(idx);
		g = 4'd15 - rgb4_t'(idx);
		return {r, g, 4'd8};
	endfunction

	function automatic logic [11:0] duck_palette(input duck_pix_t idx, input duck_color_t color);
		rgb4_t base;
		base = {idx, 1'b0};
		case (color)
			DUCK_RED:  return {4'd15, base, base};
			DUCK_PINK: return {4'd15, base, 4'd12};
			default:   return {base, base, base};
		endcase
	endfunction

endpackage

/* source/duck_hunt_config.svh */
//--------------------------------------------------------------------------
// duck hunt video configuration
// raster geometry for standard 640x480, sprite sizes, hit box margin,
// ammo layout and flash length shared by the scan-out path
//--------------------------------------------------------------------------
`ifndef DUCK_HUNT_CONFIG_SVH
`define DUCK_HUNT_CONFIG_SVH

// horizontal raster in pixels
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// vertical raster in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// sprite sizes
`define DOG_W 16
`define DOG_H 12
`define DUCK_W 12
`define DUCK_H 12

`define CURSOR_SIZE 6
`define HIT_MARGIN 2
`define AMMO_MAX 3

// short flash so a simulated frame sees all of it
`define FLASH_CYCLES 40
`define FLASH_HALF 8

// ammo squares along the bottom bar
`define AMMO_Y 418
`define AMMO_X0 68
`define AMMO_PITCH 17
`define AMMO_W 9
`define AMMO_H 13

// flat fill levels
`define AMMO_GREY 4'hA
`define BG_LEVEL 4'hB

`endif
